//--- src/frame_gen_pkg.sv
`default_nettype none

package frame_gen_pkg;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [2:0]  cfg_addr_t;
	typedef logic [31:0] cfg_word_t;

	typedef enum logic [1:0] {
		KIND_UDP  = 2'd0,
		KIND_ARP  = 2'd1,
		KIND_ICMP = 2'd2
	} frame_kind_t;

	typedef struct packed {
		logic      enable;
		mac_addr_t local_mac;
		ip_addr_t  local_ip;
		mac_addr_t peer_mac;
		ip_addr_t  peer_ip;
		udp_port_t src_port;
		udp_port_t dst_port;
	} frame_cfg_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} stream_beat_t;

	////////////////////////////////////////////////////////////
	// Register map
	localparam cfg_addr_t REG_CTRL         = 3'd0; // Bit 0 enable
	localparam cfg_addr_t REG_LOCAL_MAC_HI = 3'd1;
	localparam cfg_addr_t REG_LOCAL_MAC_LO = 3'd2;
	localparam cfg_addr_t REG_LOCAL_IP     = 3'd3;
	localparam cfg_addr_t REG_PEER_MAC_HI  = 3'd4;
	localparam cfg_addr_t REG_PEER_MAC_LO  = 3'd5;
	localparam cfg_addr_t REG_PEER_IP      = 3'd6;
	localparam cfg_addr_t REG_PORTS        = 3'd7; // Src port in upper half

	localparam mac_addr_t DEF_LOCAL_MAC = 48'h0024_7EDF_CA5E;
	localparam ip_addr_t  DEF_LOCAL_IP  = {8'd192, 8'd168, 8'd0, 8'd119};
	localparam mac_addr_t DEF_PEER_MAC  = 48'h00D0_0800_0002;
	localparam ip_addr_t  DEF_PEER_IP   = {8'd192, 8'd168, 8'd0, 8'd110};
	localparam udp_port_t DEF_PORT      = 16'd8080;

	////////////////////////////////////////////////////////////
	// Frame content
	localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
	localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
	localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;
	localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
	localparam logic [7:0]  IP_PROTO_ICMP  = 8'd1;
	localparam logic [7:0]  IP_TTL         = 8'h80;

	localparam logic [31:0]  UDP_FLAG_WORD = 32'hE1EC_0C0D;
	localparam logic [127:0] UDP_PAYLOAD   = 128'h1234_5611_1134_5678_1234_5678_AABB_CCDD;
	localparam logic [15:0]  ICMP_ID       = 16'h0001;
	localparam logic [15:0]  ICMP_SEQ      = 16'h0005;
	localparam logic [255:0] ICMP_PAYLOAD  =
		256'h6162_6364_6566_6768_696a_6b6c_6d6e_6f70_7172_7374_7576_7761_6263_6465_6667_6869;

	// Byte counts before FCS
	localparam int ETH_HDR_BYTES   = 14;
	localparam int IP_HDR_BYTES    = 20;
	localparam int ARP_BYTES       = 42;
	localparam int ICMP_BYTES      = 74;
	localparam int UDP_BYTES       = 62;
	localparam int MIN_FRAME_BYTES = 60;
	localparam int FCS_BYTES       = 4;
	localparam int MAX_BODY_BYTES  = ICMP_BYTES;
	localparam int BYTE_IDX_W      = $clog2(MAX_BODY_BYTES);

	localparam int FRAMES_PER_KIND   = 5;
	localparam int FRAME_CNT_W       = $clog2(FRAMES_PER_KIND);
	localparam int GAP_CYCLES        = 16;
	localparam int GAP_CNT_W         = $clog2(GAP_CYCLES);
	localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

	function automatic int padded_len(input int n);
		return (n < MIN_FRAME_BYTES) ? MIN_FRAME_BYTES : n;
	endfunction

endpackage

`default_nettype wire

//--- src/frame_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module frame_cfg_regs import frame_gen_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  logic       cfg_we,
	input  cfg_addr_t  cfg_addr,
	input  cfg_word_t  cfg_wdata,
	output frame_cfg_t cfg
);

	// Fields are written in place, the MACs in two halves
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg.enable    <= 1'b0;
			cfg.local_mac <= DEF_LOCAL_MAC;
			cfg.local_ip  <= DEF_LOCAL_IP;
			cfg.peer_mac  <= DEF_PEER_MAC;
			cfg.peer_ip   <= DEF_PEER_IP;
			cfg.src_port  <= DEF_PORT;
			cfg.dst_port  <= DEF_PORT;
		end else if (cfg_we) begin
			case (cfg_addr)
				REG_CTRL:         cfg.enable <= cfg_wdata[0];
				REG_LOCAL_MAC_HI: cfg.local_mac[47:32] <= cfg_wdata[15:0];
				REG_LOCAL_MAC_LO: cfg.local_mac[31:0] <= cfg_wdata;
				REG_LOCAL_IP:     cfg.local_ip <= cfg_wdata;
				REG_PEER_MAC_HI:  cfg.peer_mac[47:32] <= cfg_wdata[15:0];
				REG_PEER_MAC_LO:  cfg.peer_mac[31:0] <= cfg_wdata;
				REG_PEER_IP:      cfg.peer_ip <= cfg_wdata;
				REG_PORTS: begin
					cfg.src_port <= cfg_wdata[31:16];
					cfg.dst_port <= cfg_wdata[15:0];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/frame_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module frame_scheduler import frame_gen_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  frame_cfg_t  cfg,
	input  logic        frame_done,
	output logic        frame_start,
	output frame_kind_t frame_kind
);

	logic                   busy; // A frame is in flight
	logic [GAP_CNT_W-1:0]   gap_cnt;
	logic [FRAME_CNT_W-1:0] frame_cnt;
	logic                   gap_done;
	frame_kind_t            next_kind;

	assign gap_done = !busy && cfg.enable && (gap_cnt == GAP_CNT_W'(GAP_CYCLES - 1));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy        <= 1'b0;
			gap_cnt     <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= gap_done;
			if (gap_done)
				busy <= 1'b1;
			else if (frame_done)
				busy <= 1'b0;
			// Gap restarts while busy or disabled
			if (busy || !cfg.enable || gap_done)
				gap_cnt <= '0;
			else
				gap_cnt <= gap_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Kind rotation
	always_comb begin
		case (frame_kind)
			KIND_UDP: next_kind = KIND_ARP;
			KIND_ARP: next_kind = KIND_ICMP;
			default:  next_kind = KIND_UDP;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			frame_kind <= KIND_UDP;
			frame_cnt  <= '0;
		end else if (frame_done) begin
			if (frame_cnt == FRAME_CNT_W'(FRAMES_PER_KIND - 1)) begin
				frame_cnt  <= '0;
				frame_kind <= next_kind;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// FCS side only finishes frames that were started here
	assert property (@(posedge sys_clk) disable iff (sys_rst) frame_done |-> busy)
		else $error("frame_done with no frame in flight");

endmodule

`default_nettype wire

//--- src/frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_builder import frame_gen_pkg::*; (
	input  logic         sys_clk,
	input  logic         sys_rst,
	input  frame_cfg_t   cfg,
	input  logic         frame_start,
	input  frame_kind_t  frame_kind,
	output stream_beat_t body_beat,
	output logic         body_valid,
	input  logic         body_ready
);

	frame_cfg_t                     cur_cfg;
	frame_kind_t                    cur_kind;
	logic                           active;
	logic [BYTE_IDX_W-1:0]          byte_idx;
	logic [BYTE_IDX_W-1:0]          last_idx;
	logic [15:0]                    ip_len;
	logic [7:0]                     ip_proto;
	logic [15:0]                    ip_csum;
	logic [0:IP_HDR_BYTES-1][7:0]   ip_hdr;
	logic [0:MAX_BODY_BYTES-1][7:0] image; // Byte 0 is first on the wire

	////////////////////////////////////////////////////////////
	// Checksums
	function automatic logic [15:0] fold_sum(input logic [31:0] sum);
		logic [31:0] s;
		s = sum[15:0] + sum[31:16];
		s = s[15:0] + s[31:16];
		return ~s[15:0];
	endfunction

	function automatic logic [15:0] ip_checksum(input logic [15:0] len, input logic [7:0] proto,
			input ip_addr_t src, input ip_addr_t dst);
		logic [31:0] sum;
		sum = 32'h4500 + len + 32'h4000 + {IP_TTL, proto}
			+ src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
		return fold_sum(sum);
	endfunction

	function automatic logic [15:0] icmp_checksum(input logic [15:0] id, input logic [15:0] seq,
			input logic [255:0] payload);
		logic [31:0] sum;
		sum = 32'h0800 + id + seq;
		for (int i = 0; i < 16; i++)
			sum = sum + payload[i*16 +: 16];
		return fold_sum(sum);
	endfunction

	assign ip_csum = ip_checksum(ip_len, ip_proto, cur_cfg.local_ip, cur_cfg.peer_ip);

	// DF set, id zero
	assign ip_hdr = {8'h45, 8'h00, ip_len, 16'h0000, 16'h4000, IP_TTL, ip_proto, ip_csum,
		cur_cfg.local_ip, cur_cfg.peer_ip};

	always_comb begin
		ip_proto = IP_PROTO_UDP;
		ip_len   = 16'(UDP_BYTES - ETH_HDR_BYTES);
		last_idx = BYTE_IDX_W'(padded_len(UDP_BYTES) - 1);
		if (cur_kind == KIND_ICMP) begin
			ip_proto = IP_PROTO_ICMP;
			ip_len   = 16'(ICMP_BYTES - ETH_HDR_BYTES);
			last_idx = BYTE_IDX_W'(padded_len(ICMP_BYTES) - 1);
		end else if (cur_kind == KIND_ARP) begin
			last_idx = BYTE_IDX_W'(padded_len(ARP_BYTES) - 1);
		end
	end

	////////////////////////////////////////////////////////////
	// Frame image whose zero tail doubles as padding
	always_comb begin
		case (cur_kind)
			KIND_ARP: image = {48'hFFFF_FFFF_FFFF, cur_cfg.local_mac, ETH_TYPE_ARP,
				16'h0001, ETH_TYPE_IPV4, 8'd6, 8'd4, ARP_OP_REQUEST,
				cur_cfg.local_mac, cur_cfg.local_ip, 48'h0, cur_cfg.peer_ip,
				{((MAX_BODY_BYTES - ARP_BYTES) * 8){1'b0}}};
			KIND_ICMP: image = {cur_cfg.peer_mac, cur_cfg.local_mac, ETH_TYPE_IPV4, ip_hdr,
				8'h08, 8'h00, icmp_checksum(ICMP_ID, ICMP_SEQ, ICMP_PAYLOAD),
				ICMP_ID, ICMP_SEQ, ICMP_PAYLOAD};
			default: image = {cur_cfg.peer_mac, cur_cfg.local_mac, ETH_TYPE_IPV4, ip_hdr,
				cur_cfg.src_port, cur_cfg.dst_port,
				16'(UDP_BYTES - ETH_HDR_BYTES - IP_HDR_BYTES), 16'h0000,
				UDP_FLAG_WORD, UDP_PAYLOAD, {((MAX_BODY_BYTES - UDP_BYTES) * 8){1'b0}}};
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			active   <= 1'b0;
			byte_idx <= '0;
			cur_kind <= KIND_UDP;
		end else if (frame_start) begin
			active   <= 1'b1;
			byte_idx <= '0;
			cur_kind <= frame_kind;
		end else if (active && body_ready) begin
			if (byte_idx == last_idx) begin
				active   <= 1'b0;
				byte_idx <= '0;
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame_start)
			cur_cfg <= cfg; // Later writes wait for the next frame
	end

	assign body_valid     = active;
	assign body_beat.data = image[byte_idx];
	assign body_beat.last = (byte_idx == last_idx);

	// One frame in flight
	assert property (@(posedge sys_clk) disable iff (sys_rst) frame_start |-> !active)
		else $error("frame_start while a frame is in progress");

endmodule

`default_nettype wire

//--- src/fcs_append.sv
`timescale 1ns/1ps
`default_nettype none

module fcs_append import frame_gen_pkg::*; (
	input  logic         sys_clk,
	input  logic         sys_rst,
	input  stream_beat_t body_beat,
	input  logic         body_valid,
	output logic         body_ready,
	output stream_beat_t tx_beat,
	output logic         tx_valid,
	input  logic         tx_ready,
	output logic         frame_done
);

	logic                          fcs_phase;
	logic [$clog2(FCS_BYTES)-1:0]  fcs_idx;
	logic [31:0]                   crc;
	logic [31:0]                   fcs;
	logic                          body_xfer;
	logic                          fcs_xfer;

	// Reflected CRC-32 over one byte
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		for (int b = 0; b < 8; b++)
			r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		return r;
	endfunction

	assign fcs        = ~crc;
	assign body_ready = !fcs_phase && tx_ready;
	assign body_xfer  = body_valid && body_ready;
	assign fcs_xfer   = fcs_phase && tx_ready;

	always_comb begin
		if (fcs_phase) begin
			tx_valid     = 1'b1;
			tx_beat.data = fcs[fcs_idx*8 +: 8]; // LSB first
			tx_beat.last = (fcs_idx == $bits(fcs_idx)'(FCS_BYTES - 1));
		end else begin
			tx_valid     = body_valid;
			tx_beat.data = body_beat.data;
			tx_beat.last = 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fcs_phase  <= 1'b0;
			fcs_idx    <= '0;
			crc        <= '1;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (body_xfer) begin
				crc <= crc_byte(crc, body_beat.data);
				if (body_beat.last) begin
					fcs_phase <= 1'b1;
					fcs_idx   <= '0;
				end
			end else if (fcs_xfer) begin
				if (tx_beat.last) begin
					fcs_phase  <= 1'b0;
					crc        <= '1;
					frame_done <= 1'b1;
				end else begin
					fcs_idx <= fcs_idx + 1'b1;
				end
			end
		end
	end

	// Held beat covers the builder side too
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
		else $error("tx_beat changed during a stall");

endmodule

`default_nettype wire

//--- src/frame_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_gen_top import frame_gen_pkg::*; (
	input  logic         sys_clk,
	input  logic         sys_rst,
	input  logic         cfg_we,
	input  cfg_addr_t    cfg_addr,
	input  cfg_word_t    cfg_wdata,
	output stream_beat_t tx_beat,
	output logic         tx_valid,
	input  logic         tx_ready
);

	frame_cfg_t   cfg;
	logic         frame_start;
	frame_kind_t  frame_kind;
	stream_beat_t body_beat;
	logic         body_valid;
	logic         body_ready;
	logic         frame_done;

	frame_cfg_regs u_cfg_regs (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	frame_scheduler u_scheduler (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.cfg         (cfg),
		.frame_done  (frame_done),
		.frame_start (frame_start),
		.frame_kind  (frame_kind)
	);

	////////////////////////////////////////////////////////////
	// Body bytes, then CRC on the way out
	frame_builder u_builder (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.cfg         (cfg),
		.frame_start (frame_start),
		.frame_kind  (frame_kind),
		.body_beat   (body_beat),
		.body_valid  (body_valid),
		.body_ready  (body_ready)
	);

	fcs_append u_fcs (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.body_beat  (body_beat),
		.body_valid (body_valid),
		.body_ready (body_ready),
		.tx_beat    (tx_beat),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.frame_done (frame_done)
	);

endmodule

`default_nettype wire

//--- tests/frame_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_gen_tb import frame_gen_pkg::*; ();

	localparam int          N_IMAGES     = 4;
	localparam int          TD_WORDS     = 512;
	localparam int          RX_MAX       = MAX_BODY_BYTES + FCS_BYTES;
	localparam int          WR_ENABLE    = 0; // Write records in file order
	localparam int          WR_PEER_IP   = 1;
	localparam int          WR_DISABLE   = 2;
	localparam int          N_FRAMES     = 34;
	localparam int          CYCLE_LIMIT  = 2 * N_FRAMES * (RX_MAX + GAP_CYCLES + 2)
		+ 2 * (GAP_CYCLES + 100) + 100;
	localparam logic [31:0] LFSR_SEED    = 32'h8c25_b20a;
	localparam logic [31:0] ETH_GEN_POLY = 32'h04C1_1DB7; // 802.3 generator in MSB-first form

	logic         sys_clk;
	logic         sys_rst;
	logic         cfg_we;
	cfg_addr_t    cfg_addr;
	cfg_word_t    cfg_wdata;
	stream_beat_t tx_beat;
	logic         tx_valid;
	logic         tx_ready;

	logic [31:0]  td [0:TD_WORDS-1];
	cfg_addr_t    wr_addr [0:7];
	cfg_word_t    wr_data [0:7];
	int           wr_cnt;
	logic [7:0]   img [0:N_IMAGES-1][0:RX_MAX-1]; // Body plus FCS
	int           img_len [0:N_IMAGES-1];
	stream_beat_t rx_beats [0:RX_MAX-1];
	int           rx_len;
	int           frames_seen;
	logic         use_lfsr;
	logic         peer_changed;
	logic [31:0]  lfsr;
	int           cycle_cnt = 0;

	frame_gen_top u_dut (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.tx_beat   (tx_beat),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready)
	);

	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	////////////////////////////////////////////////////////////
	// Error handling and compare tasks
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_beat(input string name, input stream_beat_t got,
			input stream_beat_t exp);
		if (got !== exp)
			stop_on_error($sformatf(
				"ERROR at %0t: %s got data %02h last %0b, expected data %02h last %0b",
				$time, name, got.data, got.last, exp.data, exp.last));
	endtask

	task automatic check_kind_sequence(input frame_kind_t got, input frame_kind_t exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: frame kind of frame %0d got %s, expected %s",
				$time, frames_seen, got.name(), exp.name()));
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("ERROR at %0t: %s got %0b, expected %0b",
				$time, name, got, exp));
	endtask

	// Serial CRC in the non-reflected form with bits fed LSB first as on the wire
	function automatic logic [31:0] crc_shift_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r  = {r[30:0], 1'b0} ^ (fb ? ETH_GEN_POLY : 32'h0);
		end
		return r;
	endfunction

	function automatic logic [31:0] bit_reverse(input logic [31:0] v);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = v[31-i];
		return r;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
	endfunction

	task automatic load_testdata();
		int          p;
		int          id;
		int          n;
		logic [31:0] crc;
		logic [31:0] fcs;
		$readmemh("tests/frame_gen_testdata.txt", td);
		p      = 0;
		wr_cnt = 0;
		for (int i = 0; i < N_IMAGES; i++)
			img_len[i] = 0;
		while (p < TD_WORDS - 3 && !$isunknown(td[p]) && td[p] != 0) begin
			if (td[p] == 1 && wr_cnt < 8) begin
				wr_addr[wr_cnt] = cfg_addr_t'(td[p+1]);
				wr_data[wr_cnt] = td[p+2];
				wr_cnt++;
				p += 3;
			end else if (td[p] == 2 && td[p+1] < N_IMAGES && td[p+2] <= MAX_BODY_BYTES) begin
				id  = td[p+1];
				n   = td[p+2];
				crc = '1;
				for (int i = 0; i < n; i++) begin
					img[id][i] = td[p+3+i][7:0];
					crc        = crc_shift_byte(crc, td[p+3+i][7:0]);
				end
				fcs = ~bit_reverse(crc);
				for (int i = 0; i < FCS_BYTES; i++)
					img[id][n+i] = fcs[i*8 +: 8];
				img_len[id] = n + FCS_BYTES;
				p += 3 + n;
			end else begin
				stop_on_error($sformatf("Test data has a bad record at word %0d", p));
			end
		end
		if (wr_cnt < 3)
			stop_on_error("Test data holds fewer than three configuration writes");
		for (int i = 0; i < N_IMAGES; i++)
			if (img_len[i] == 0)
				stop_on_error($sformatf("Test data has no frame image %0d", i));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and frame capture
	task automatic write_cfg(input int idx);
		@(posedge sys_clk);
		#1;
		cfg_we    = 1'b1;
		cfg_addr  = wr_addr[idx];
		cfg_wdata = wr_data[idx];
		@(posedge sys_clk);
		#1;
		cfg_we = 1'b0;
	endtask

	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge sys_clk);
			check_valid("tx_valid", tx_valid, 1'b0);
		end
	endtask

	task automatic receive_frame();
		stream_beat_t held;
		logic         stalled;
		logic         done;
		rx_len  = 0;
		stalled = 1'b0;
		done    = 1'b0;
		while (!done) begin
			@(posedge sys_clk);
			#1;
			if (use_lfsr) begin
				lfsr     = lfsr_step(lfsr);
				tx_ready = lfsr[0];
			end else begin
				tx_ready = 1'b1;
			end
			@(negedge sys_clk); // Beat transfers on the next rising edge
			if (stalled) begin
				check_valid("tx_valid under stall", tx_valid, 1'b1);
				check_beat("tx_beat under stall", tx_beat, held);
			end
			stalled = tx_valid && !tx_ready;
			held    = tx_beat;
			if (tx_valid && tx_ready) begin
				rx_beats[rx_len] = tx_beat;
				rx_len++;
				done = tx_beat.last || rx_len == RX_MAX;
			end
		end
	endtask

	function automatic frame_kind_t kind_of_frame();
		if ({rx_beats[12].data, rx_beats[13].data} == ETH_TYPE_ARP)
			return KIND_ARP;
		if (rx_beats[23].data == IP_PROTO_ICMP)
			return KIND_ICMP;
		return KIND_UDP;
	endfunction

	function automatic int image_for(input frame_kind_t k);
		case (k)
			KIND_ARP:  return 1;
			KIND_ICMP: return 2;
			default:   return peer_changed ? 3 : 0;
		endcase
	endfunction

	task automatic check_frame();
		frame_kind_t  exp_kind;
		stream_beat_t exp;
		int           id;
		exp_kind = frame_kind_t'((frames_seen / FRAMES_PER_KIND) % 3);
		check_kind_sequence(kind_of_frame(), exp_kind);
		id = image_for(exp_kind);
		for (int i = 0; i < img_len[id]; i++) begin
			exp.data = img[id][i];
			exp.last = (i == img_len[id] - 1);
			check_beat($sformatf("tx_beat[%0d] of frame %0d", i, frames_seen), rx_beats[i], exp);
		end
		frames_seen++;
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
			stop_on_error($sformatf("Timeout after %0d cycles, frames stopped arriving",
				cycle_cnt));
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		sys_rst      = 1'b1;
		cfg_we       = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		tx_ready     = 1'b0;
		use_lfsr     = 1'b0;
		peer_changed = 1'b0;
		frames_seen  = 0;
		rx_len       = 0;
		lfsr         = LFSR_SEED;
		load_testdata();
		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst  = 1'b0;
		tx_ready = 1'b1;

		expect_idle(100); // Still disabled

		// First frame, then the rest of the rotation
		write_cfg(WR_ENABLE);
		repeat (16) begin
			receive_frame();
			check_frame();
		end

		use_lfsr = 1'b1;
		repeat (15) begin
			receive_frame();
			check_frame();
		end

		// Peer IP moves while a UDP frame is on the wire
		rx_len = 0;
		fork
			receive_frame();
			begin
				wait (rx_len >= 20);
				write_cfg(WR_PEER_IP);
			end
		join
		check_frame();
		peer_changed = 1'b1;
		receive_frame();
		check_frame();

		rx_len = 0;
		fork
			receive_frame();
			begin
				wait (rx_len >= 10);
				write_cfg(WR_DISABLE);
			end
		join
		check_frame();
		@(posedge sys_clk);
		#1;
		tx_ready = 1'b1;
		expect_idle(GAP_CYCLES + 100);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/frame_gen_testdata.txt
// Tag 1: configuration write, then register index and write data
// Tag 2: frame body image, then image id, byte count and bytes in wire order (FCS excluded)
// Writes in order: enable, peer IP 192.168.0.111, disable
1 0 00000001
1 6 c0a8006f
1 0 00000000
// Image 0: UDP with default addresses
2 0 3e
00 d0 08 00 00 02 00 24 7e df ca 5e 08 00
45 00 00 30 00 00 40 00 80 11 78 87 c0 a8 00 77 c0 a8 00 6e
1f 90 1f 90 00 1c 00 00 e1 ec 0c 0d
12 34 56 11 11 34 56 78 12 34 56 78 aa bb cc dd
// Image 1: ARP request, padded to 60 bytes
2 1 3c
ff ff ff ff ff ff 00 24 7e df ca 5e 08 06
00 01 08 00 06 04 00 01 00 24 7e df ca 5e c0 a8 00 77
00 00 00 00 00 00 c0 a8 00 6e
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// Image 2: ICMP echo request
2 2 4a
00 d0 08 00 00 02 00 24 7e df ca 5e 08 00
45 00 00 3c 00 00 40 00 80 01 78 8b c0 a8 00 77 c0 a8 00 6e
08 00 4d 56 00 01 00 05
61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70
71 72 73 74 75 76 77 61 62 63 64 65 66 67 68 69
// Image 3: UDP after the peer IP write
2 3 3e
00 d0 08 00 00 02 00 24 7e df ca 5e 08 00
45 00 00 30 00 00 40 00 80 11 78 86 c0 a8 00 77 c0 a8 00 6f
1f 90 1f 90 00 1c 00 00 e1 ec 0c 0d
12 34 56 11 11 34 56 78 12 34 56 78 aa bb cc dd
0

//--- flist.f
src/frame_gen_pkg.sv
src/frame_cfg_regs.sv
src/frame_scheduler.sv
src/frame_builder.sv
src/fcs_append.sv
src/frame_gen_top.sv
tests/frame_gen_tb.sv

//--- Bender.yml
package:
  name: frame_gen

sources:
  - files:
      - src/frame_gen_pkg.sv
      - src/frame_cfg_regs.sv
      - src/frame_scheduler.sv
      - src/frame_builder.sv
      - src/fcs_append.sv
      - src/frame_gen_top.sv
  - target: test
    files:
      - tests/frame_gen_tb.sv
